/* build.f */
source/isa_pkg.sv
source/pipe_pkg.sv
source/pipe_if.sv
source/fetch_stage.sv
source/id.sv
source/regfile.sv
source/ex.sv
source/ex_mem_wb.sv
source/hilo.sv
source/openmips.sv
verif/openmips_sva.sv
verif/tb_openmips.sv

/* run_sim.sh */
#!/bin/sh
# build the openmips testbench with Verilator, run it and look for the pass line in the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_openmips -f build.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

grep -q "TESTBENCH PASSED" sim.log
echo "simulation log in sim.log"

/* source/ex.sv */
// execute stage, logic and add/sub ALU, unsigned multiply and HI/LO moves
module ex (
    exe_bus_if.dst              bus,
    result_if.src               res,
    input  pipe_pkg::word_t     hi_i,  // forwarded current HI
    input  pipe_pkg::word_t     lo_i,
    output logic                fwd_wreg_o,
    output pipe_pkg::reg_addr_t fwd_waddr_o,
    output pipe_pkg::word_t     fwd_wdata_o
);
    import pipe_pkg::*;

    logic [63:0] prod;
    word_t       result;

    assign prod = {32'b0, bus.src_a} * {32'b0, bus.src_b};

    always_comb begin
        result    = '0;
        res.hi_we = 1'b0;
        res.lo_we = 1'b0;
        res.hi    = prod[63:32];
        res.lo    = prod[31:0];
        case (bus.aluop)
            ALU_OR:   result = bus.src_a | bus.src_b;
            ALU_AND:  result = bus.src_a & bus.src_b;
            ALU_XOR:  result = bus.src_a ^ bus.src_b;
            ALU_ADD:  result = bus.src_a + bus.src_b;
            ALU_SUB:  result = bus.src_a - bus.src_b;  // wraps, no overflow trap
            ALU_LUI:  result = bus.src_b;
            ALU_MFHI: result = hi_i;
            ALU_MFLO: result = lo_i;
            ALU_MULTU: begin
                res.hi_we = 1'b1;
                res.lo_we = 1'b1;
            end
            ALU_MTHI: begin
                res.hi_we = 1'b1;
                res.hi    = bus.src_a;
            end
            ALU_MTLO: begin
                res.lo_we = 1'b1;
                res.lo    = bus.src_a;
            end
            default: result = '0;
        endcase
    end

    assign res.waddr = bus.waddr;
    assign res.wreg  = bus.wreg;
    assign res.wdata = result;

    // bypass toward decode
    assign fwd_wreg_o  = bus.wreg;
    assign fwd_waddr_o = bus.waddr;
    assign fwd_wdata_o = result;

endmodule

/* source/ex_mem_wb.sv */
// EX/MEM and MEM/WB registers, the MEM stage passes results straight through
module ex_mem_wb (
    input  logic                clk,
    input  logic                rst_i,
    result_if.dst               res,
    output logic                mem_wreg_o,
    output pipe_pkg::reg_addr_t mem_waddr_o,
    output pipe_pkg::word_t     mem_wdata_o,
    output logic                wb_wreg_o,
    output pipe_pkg::reg_addr_t wb_waddr_o,
    output pipe_pkg::word_t     wb_wdata_o,
    output logic                mem_hi_we_o,
    output logic                mem_lo_we_o,
    output pipe_pkg::word_t     mem_hi_o,
    output pipe_pkg::word_t     mem_lo_o,
    output logic                wb_hi_we_o,
    output logic                wb_lo_we_o,
    output pipe_pkg::word_t     wb_hi_o,
    output pipe_pkg::word_t     wb_lo_o
);

    // write enables
    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_wreg_o  <= 1'b0;
            mem_hi_we_o <= 1'b0;
            mem_lo_we_o <= 1'b0;
            wb_wreg_o   <= 1'b0;
            wb_hi_we_o  <= 1'b0;
            wb_lo_we_o  <= 1'b0;
        end else begin
            mem_wreg_o  <= res.wreg;
            mem_hi_we_o <= res.hi_we;
            mem_lo_we_o <= res.lo_we;
            wb_wreg_o   <= mem_wreg_o;
            wb_hi_we_o  <= mem_hi_we_o;
            wb_lo_we_o  <= mem_lo_we_o;
        end
    end

    always_ff @(posedge clk) begin
        mem_waddr_o <= res.waddr;
        mem_wdata_o <= res.wdata;
        mem_hi_o    <= res.hi;
        mem_lo_o    <= res.lo;
        wb_waddr_o  <= mem_waddr_o;  // data memory would sit here
        wb_wdata_o  <= mem_wdata_o;
        wb_hi_o     <= mem_hi_o;
        wb_lo_o     <= mem_lo_o;
    end

endmodule

/* source/fetch_stage.sv */
// program counter and IF/ID register, drives the instruction ROM enable and address
module fetch_stage #(
    parameter pipe_pkg::pc_t RESET_PC = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           rst_i,
    input  isa_pkg::inst_t rom_data_i,
    output logic           rom_ce_o,
    output pipe_pkg::pc_t  rom_addr_o,
    output isa_pkg::inst_t id_inst_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rom_ce_o   <= 1'b0;
            rom_addr_o <= RESET_PC;
            id_inst_o  <= '0;  // all zero word decodes as nop
        end else begin
            rom_ce_o <= 1'b1;
            // first enabled cycle presents RESET_PC itself
            if (rom_ce_o) begin
                rom_addr_o <= rom_addr_o + 32'd4;
            end
            id_inst_o <= rom_ce_o ? rom_data_i : '0;
        end
    end

endmodule

/* source/hilo.sv */
// HI and LO registers, written at WB and forwarded from MEM and WB to execute
module hilo (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            mem_hi_we_i,
    input  logic            mem_lo_we_i,
    input  pipe_pkg::word_t mem_hi_i,
    input  pipe_pkg::word_t mem_lo_i,
    input  logic            wb_hi_we_i,
    input  logic            wb_lo_we_i,
    input  pipe_pkg::word_t wb_hi_i,
    input  pipe_pkg::word_t wb_lo_i,
    output pipe_pkg::word_t hi_o,
    output pipe_pkg::word_t lo_o
);
    import pipe_pkg::*;

    word_t hi_q;
    word_t lo_q;

    // MEM is younger than WB
    function automatic word_t pick(input logic mem_we, input word_t mem_v,
                                   input logic wb_we, input word_t wb_v,
                                   input word_t cur);
        return mem_we ? mem_v : (wb_we ? wb_v : cur);
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (wb_hi_we_i) hi_q <= wb_hi_i;
            if (wb_lo_we_i) lo_q <= wb_lo_i;
        end
    end

    assign hi_o = pick(mem_hi_we_i, mem_hi_i, wb_hi_we_i, wb_hi_i, hi_q);
    assign lo_o = pick(mem_lo_we_i, mem_lo_i, wb_lo_we_i, wb_lo_i, lo_q);

endmodule

/* source/id.sv */
// instruction decode and ID/EX register, reads operands from the register file
module id (
    input  logic                clk,
    input  logic                rst_i,
    input  isa_pkg::inst_t      inst_i,
    output pipe_pkg::reg_addr_t raddr1_o,
    output logic                re1_o,
    output pipe_pkg::reg_addr_t raddr2_o,
    output logic                re2_o,
    input  pipe_pkg::word_t     rdata1_i,
    input  pipe_pkg::word_t     rdata2_i,
    exe_bus_if.src              bus
);
    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_t          opcode;
    funct_t           funct;
    reg_addr_t        rs;
    reg_addr_t        rt;
    reg_addr_t        rd;
    logic [IMM_W-1:0] imm;
    alu_op_e          aluop;
    reg_addr_t        waddr;
    logic             wreg;
    logic             use_imm;
    word_t            imm_ext;

    assign opcode   = inst_i[31:26];
    assign rs       = inst_i[25:21];
    assign rt       = inst_i[20:16];
    assign rd       = inst_i[15:11];
    assign funct    = inst_i[5:0];
    assign imm      = inst_i[IMM_W-1:0];
    assign raddr1_o = rs;
    assign raddr2_o = rt;

    always_comb begin
        aluop   = ALU_NOP;  // unknown encodings fall through as nop
        re1_o   = 1'b0;
        re2_o   = 1'b0;
        waddr   = rd;
        wreg    = 1'b0;
        use_imm = 1'b0;
        imm_ext = {{(32 - IMM_W){1'b0}}, imm};  // zero extend for logic ops
        case (opcode)
            OP_ORI, OP_ANDI, OP_XORI: begin
                aluop   = (opcode == OP_ORI)  ? ALU_OR :
                          (opcode == OP_ANDI) ? ALU_AND : ALU_XOR;
                re1_o   = 1'b1;
                waddr   = rt;
                wreg    = 1'b1;
                use_imm = 1'b1;
            end
            OP_LUI: begin
                aluop   = ALU_LUI;
                waddr   = rt;
                wreg    = 1'b1;
                use_imm = 1'b1;
                imm_ext = {imm, {(32 - IMM_W){1'b0}}};
            end
            OP_SPECIAL: begin
                case (funct)
                    FN_ADDU:  aluop = ALU_ADD;
                    FN_SUBU:  aluop = ALU_SUB;
                    FN_AND:   aluop = ALU_AND;
                    FN_OR:    aluop = ALU_OR;
                    FN_XOR:   aluop = ALU_XOR;
                    FN_MULTU: aluop = ALU_MULTU;
                    FN_MFHI:  aluop = ALU_MFHI;
                    FN_MFLO:  aluop = ALU_MFLO;
                    FN_MTHI:  aluop = ALU_MTHI;
                    FN_MTLO:  aluop = ALU_MTLO;
                    default:  aluop = ALU_NOP;
                endcase
                re1_o = aluop inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                                      ALU_MULTU, ALU_MTHI, ALU_MTLO};
                re2_o = aluop inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_MULTU};
                wreg  = aluop inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                                      ALU_MFHI, ALU_MFLO};
            end
            default: ;
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            bus.aluop <= ALU_NOP;
            bus.wreg  <= 1'b0;
        end else begin
            bus.aluop <= aluop;
            bus.wreg  <= wreg && (waddr != '0);  // r0 writes are dropped here
        end
    end

    always_ff @(posedge clk) begin
        bus.src_a <= rdata1_i;
        bus.src_b <= use_imm ? imm_ext : rdata2_i;
        bus.waddr <= waddr;
    end

endmodule

/* source/isa_pkg.sv */
// MIPS32 instruction encodings, imported by decode and by the testbench encoder and model
package isa_pkg;

    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;
    localparam int IMM_W    = 16;

    typedef logic [31:0]         inst_t;
    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [FUNCT_W-1:0]  funct_t;

    // primary opcodes, bits 31:26
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;

    // SPECIAL function field, bits 5:0
    localparam funct_t FN_MFHI  = 6'b010000;
    localparam funct_t FN_MTHI  = 6'b010001;
    localparam funct_t FN_MFLO  = 6'b010010;
    localparam funct_t FN_MTLO  = 6'b010011;
    localparam funct_t FN_MULTU = 6'b011001;
    localparam funct_t FN_ADDU  = 6'b100001;
    localparam funct_t FN_SUBU  = 6'b100011;
    localparam funct_t FN_AND   = 6'b100100;
    localparam funct_t FN_OR    = 6'b100101;
    localparam funct_t FN_XOR   = 6'b100110;

endpackage

/* source/openmips.sv */
// top level of the five-stage core, connect an instruction ROM and watch the write-back ports
module openmips #(
    parameter pipe_pkg::pc_t RESET_PC = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                rst_i,
    input  isa_pkg::inst_t      rom_data_i,  // valid in the same cycle as rom_addr_o
    output logic                rom_ce_o,
    output pipe_pkg::pc_t       rom_addr_o,
    output logic                wb_we_o,
    output pipe_pkg::reg_addr_t wb_waddr_o,
    output pipe_pkg::word_t     wb_wdata_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    inst_t     id_inst;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    logic      re1;
    logic      re2;
    word_t     rdata1;
    word_t     rdata2;

    // forwarding from the EX and MEM stages
    logic      ex_wreg;
    reg_addr_t ex_waddr;
    word_t     ex_wdata;
    logic      mem_wreg;
    reg_addr_t mem_waddr;
    word_t     mem_wdata;

    logic      mem_hi_we;
    logic      mem_lo_we;
    word_t     mem_hi;
    word_t     mem_lo;
    logic      wb_hi_we;
    logic      wb_lo_we;
    word_t     wb_hi;
    word_t     wb_lo;
    word_t     cur_hi;
    word_t     cur_lo;

    exe_bus_if exe_bus ();
    result_if  ex_res ();

    fetch_stage #(.RESET_PC(RESET_PC)) fetch_0 (
        .clk(clk), .rst_i(rst_i),
        .rom_data_i(rom_data_i), .rom_ce_o(rom_ce_o), .rom_addr_o(rom_addr_o),
        .id_inst_o(id_inst)
    );

    id id_0 (
        .clk(clk), .rst_i(rst_i), .inst_i(id_inst),
        .raddr1_o(raddr1), .re1_o(re1), .raddr2_o(raddr2), .re2_o(re2),
        .rdata1_i(rdata1), .rdata2_i(rdata2),
        .bus(exe_bus)
    );

    regfile regfile_0 (
        .clk(clk), .rst_i(rst_i),
        .raddr1_i(raddr1), .re1_i(re1), .raddr2_i(raddr2), .re2_i(re2),
        .rdata1_o(rdata1), .rdata2_o(rdata2),
        .ex_wreg_i(ex_wreg), .ex_waddr_i(ex_waddr), .ex_wdata_i(ex_wdata),
        .mem_wreg_i(mem_wreg), .mem_waddr_i(mem_waddr), .mem_wdata_i(mem_wdata),
        .wb_wreg_i(wb_we_o), .wb_waddr_i(wb_waddr_o), .wb_wdata_i(wb_wdata_o)
    );

    ex ex_0 (
        .bus(exe_bus), .res(ex_res),
        .hi_i(cur_hi), .lo_i(cur_lo),
        .fwd_wreg_o(ex_wreg), .fwd_waddr_o(ex_waddr), .fwd_wdata_o(ex_wdata)
    );

    ex_mem_wb ex_mem_wb_0 (
        .clk(clk), .rst_i(rst_i), .res(ex_res),
        .mem_wreg_o(mem_wreg), .mem_waddr_o(mem_waddr), .mem_wdata_o(mem_wdata),
        .wb_wreg_o(wb_we_o), .wb_waddr_o(wb_waddr_o), .wb_wdata_o(wb_wdata_o),
        .mem_hi_we_o(mem_hi_we), .mem_lo_we_o(mem_lo_we), .mem_hi_o(mem_hi), .mem_lo_o(mem_lo),
        .wb_hi_we_o(wb_hi_we), .wb_lo_we_o(wb_lo_we), .wb_hi_o(wb_hi), .wb_lo_o(wb_lo)
    );

    hilo hilo_0 (
        .clk(clk), .rst_i(rst_i),
        .mem_hi_we_i(mem_hi_we), .mem_lo_we_i(mem_lo_we), .mem_hi_i(mem_hi), .mem_lo_i(mem_lo),
        .wb_hi_we_i(wb_hi_we), .wb_lo_we_i(wb_lo_we), .wb_hi_i(wb_hi), .wb_lo_i(wb_lo),
        .hi_o(cur_hi), .lo_o(cur_lo)
    );

endmodule

/* source/pipe_if.sv */
// stage-to-stage buses, decode to execute and execute to the result registers
interface exe_bus_if;
    import pipe_pkg::*;

    alu_op_e   aluop;
    word_t     src_a;
    word_t     src_b;  // already holds the extended immediate
    reg_addr_t waddr;
    logic      wreg;

    modport src (output aluop, src_a, src_b, waddr, wreg);
    modport dst (input aluop, src_a, src_b, waddr, wreg);
endinterface

interface result_if;
    import pipe_pkg::*;

    reg_addr_t waddr;
    logic      wreg;
    word_t     wdata;
    logic      hi_we;
    logic      lo_we;
    word_t     hi;
    word_t     lo;

    modport src (output waddr, wreg, wdata, hi_we, lo_we, hi, lo);
    modport dst (input waddr, wreg, wdata, hi_we, lo_we, hi, lo);
endinterface

/* source/pipe_pkg.sv */
// datapath types shared by the pipeline stages of the core
package pipe_pkg;

    typedef logic [31:0] word_t;     // register value
    typedef logic [4:0]  reg_addr_t; // register number
    typedef logic [31:0] pc_t;       // byte address

    // operation passed from decode to execute
    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_OR,
        ALU_AND,
        ALU_XOR,
        ALU_ADD,
        ALU_SUB,
        ALU_LUI,
        ALU_MULTU,
        ALU_MFHI,
        ALU_MFLO,
        ALU_MTHI,
        ALU_MTLO
    } alu_op_e;

endpackage

/* source/regfile.sv */
// 32 x 32 general register file, two read ports with bypass from EX, MEM and WB
module regfile (
    input  logic                clk,
    input  logic                rst_i,
    input  pipe_pkg::reg_addr_t raddr1_i,
    input  logic                re1_i,
    input  pipe_pkg::reg_addr_t raddr2_i,
    input  logic                re2_i,
    output pipe_pkg::word_t     rdata1_o,
    output pipe_pkg::word_t     rdata2_o,
    input  logic                ex_wreg_i,
    input  pipe_pkg::reg_addr_t ex_waddr_i,
    input  pipe_pkg::word_t     ex_wdata_i,
    input  logic                mem_wreg_i,
    input  pipe_pkg::reg_addr_t mem_waddr_i,
    input  pipe_pkg::word_t     mem_wdata_i,
    input  logic                wb_wreg_i,
    input  pipe_pkg::reg_addr_t wb_waddr_i,
    input  pipe_pkg::word_t     wb_wdata_i
);
    import pipe_pkg::*;

    word_t regs [32];

    // youngest pending write wins
    function automatic word_t read_port(input reg_addr_t addr, input logic re);
        word_t val;
        if (!re || addr == '0) begin
            val = '0;
        end else if (ex_wreg_i && ex_waddr_i == addr) begin
            val = ex_wdata_i;
        end else if (mem_wreg_i && mem_waddr_i == addr) begin
            val = mem_wdata_i;
        end else if (wb_wreg_i && wb_waddr_i == addr) begin
            val = wb_wdata_i;  // write-through
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_i && wb_wreg_i && wb_waddr_i != '0) begin
            regs[wb_waddr_i] <= wb_wdata_i;
        end
    end

    always_comb begin
        rdata1_o = read_port(raddr1_i, re1_i);
        rdata2_o = read_port(raddr2_i, re2_i);
    end

endmodule

/* verif/openmips_sva.sv */
// protocol assertions for the core's ROM and write-back ports, attached to openmips by bind
module openmips_sva (
    input logic                clk,
    input logic                rst_i,
    input logic                rom_ce_i,
    input pipe_pkg::pc_t       rom_addr_i,
    input logic                wb_we_i,
    input pipe_pkg::reg_addr_t wb_waddr_i
);

    // r0 writes are dropped in decode and must never retire
    a_no_r0_write: assert property (@(posedge clk) disable iff (rst_i)
        wb_we_i |-> wb_waddr_i != '0)
        else $error("write to register zero reached write-back");

    a_ce_low_in_reset: assert property (@(posedge clk) rst_i |=> !rom_ce_i)
        else $error("ROM enable high while in reset");

    a_pc_step: assert property (@(posedge clk) disable iff (rst_i)
        rom_ce_i |=> rom_addr_i == $past(rom_addr_i) + 32'd4)  // no stalls, no branches
        else $error("ROM address did not advance by 4");

endmodule

bind openmips openmips_sva u_sva (
    .clk(clk), .rst_i(rst_i), .rom_ce_i(rom_ce_o), .rom_addr_i(rom_addr_o),
    .wb_we_i(wb_we_o), .wb_waddr_i(wb_waddr_o)
);

/* verif/tb_openmips.sv */
// directed testbench for openmips, runs small programs from a ROM model against an ISA model
module tb_openmips;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam pc_t   RESET_PC  = 32'h0000_1000;
    localparam int    ROM_WORDS = 64;
    localparam word_t LFSR_POLY = 32'h8020_0003;

    logic      clk;
    logic      rst_i;
    inst_t     rom_data_i;
    logic      rom_ce_o;
    pc_t       rom_addr_o;
    logic      wb_we_o;
    reg_addr_t wb_waddr_o;
    word_t     wb_wdata_o;

    inst_t       rom [ROM_WORDS];
    pc_t         rom_idx;
    inst_t       prog [$];
    word_t       exp_addr [$];
    word_t       exp_data [$];
    word_t       mreg [32];  // model register file
    word_t       mhi;
    word_t       mlo;
    logic [31:0] lfsr = 32'h869c_363d;
    int          n_tests = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 10;  // grows as each test starts

    openmips #(.RESET_PC(RESET_PC)) u_dut (
        .clk(clk), .rst_i(rst_i), .rom_data_i(rom_data_i),
        .rom_ce_o(rom_ce_o), .rom_addr_o(rom_addr_o),
        .wb_we_o(wb_we_o), .wb_waddr_o(wb_waddr_o), .wb_wdata_o(wb_wdata_o)
    );

    // same-cycle ROM, words past the program read as nop
    assign rom_idx    = (rom_addr_o - RESET_PC) >> 2;
    assign rom_data_i = (rom_idx < 32'(ROM_WORDS)) ? rom[rom_idx[5:0]] : '0;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles, expected writes never arrived", cycle_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_POLY : 32'h0);
        end
        return v;
    endfunction

    function automatic inst_t enc_r(input funct_t fn, input reg_addr_t rd,
                                    input reg_addr_t rs, input reg_addr_t rt);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic inst_t enc_i(input opcode_t op, input reg_addr_t rs,
                                    input reg_addr_t rt, input word_t imm);
        return {op, rs, rt, imm[15:0]};
    endfunction

    task automatic load_const(input reg_addr_t rd, input word_t value);
        prog.push_back(enc_i(OP_LUI, 5'd0, rd, value >> 16));
        prog.push_back(enc_i(OP_ORI, rd, rd, value));
    endtask

    task automatic check_eq(input string what, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail at time %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // one instruction of the ISA, queues its register write in program order
    task automatic model_exec(input inst_t in);
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   dst;
        word_t       a;
        word_t       b;
        word_t       imm_z;
        word_t       res;
        logic        wr;
        logic [63:0] p;
        rs    = in[25:21];
        rt    = in[20:16];
        dst   = in[15:11];
        a     = mreg[rs];
        b     = mreg[rt];
        imm_z = {16'h0, in[15:0]};
        res   = '0;
        wr    = 1'b1;
        case (in[31:26])
            OP_ORI: begin
                res = a | imm_z;
                dst = rt;
            end
            OP_ANDI: begin
                res = a & imm_z;
                dst = rt;
            end
            OP_XORI: begin
                res = a ^ imm_z;
                dst = rt;
            end
            OP_LUI: begin
                res = {in[15:0], 16'h0};
                dst = rt;
            end
            OP_SPECIAL: begin
                case (in[5:0])
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_MFHI: res = mhi;
                    FN_MFLO: res = mlo;
                    FN_MULTU: begin
                        p   = {32'h0, a} * {32'h0, b};
                        mhi = p[63:32];
                        mlo = p[31:0];
                        wr  = 1'b0;
                    end
                    FN_MTHI: begin
                        mhi = a;
                        wr  = 1'b0;
                    end
                    FN_MTLO: begin
                        mlo = a;
                        wr  = 1'b0;
                    end
                    default: wr = 1'b0;
                endcase
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != '0) begin  // r0 stays zero
            mreg[dst] = res;
            exp_addr.push_back({27'h0, dst});
            exp_data.push_back(res);
        end
    endtask

    // reset, load, then match every retired write against the model
    task automatic run_program(input string name);
        int cyc;
        int seen;
        int t_fetch;
        int t_first;
        int drain;
        int err0;
        cyc     = 0;
        seen    = 0;
        t_fetch = -1;
        t_first = -1;
        drain   = 0;
        err0    = n_errors;
        cycle_limit += prog.size() + 20;  // reset, pipeline fill and drain
        exp_addr.delete();
        exp_data.delete();
        @(posedge clk);
        rst_i <= 1'b1;
        @(posedge clk);  // fetch is held in reset from this edge
        for (int k = 0; k < ROM_WORDS; k++) rom[k] = (k < prog.size()) ? prog[k] : '0;
        for (int k = 0; k < 32; k++) mreg[k] = '0;
        mhi = '0;
        mlo = '0;
        foreach (prog[k]) model_exec(prog[k]);
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        while (seen < exp_addr.size() || drain < 4) begin
            @(negedge clk);  // outputs settled
            cyc++;
            if (rom_ce_o && rom_addr_o == RESET_PC && t_fetch < 0) t_fetch = cyc;
            if (wb_we_o) begin
                if (t_first < 0) t_first = cyc;
                if (seen < exp_addr.size()) begin
                    check_eq({name, " write address"}, {27'h0, wb_waddr_o}, exp_addr[seen]);
                    check_eq({name, " write data"}, wb_wdata_o, exp_data[seen]);
                    seen++;
                end else begin
                    $display("%s: unexpected write to r%0d at time %0t", name, wb_waddr_o, $time);
                    n_errors++;
                end
            end
            if (seen >= exp_addr.size()) drain++;
        end
        // every program opens with a register write
        check_eq({name, " first write latency"}, 32'(t_first - t_fetch), 32'd4);
        n_tests++;
        $display("test %s done: %0d writes, %0d errors", name, seen, n_errors - err0);
    endtask

    task automatic test_immediate();
        prog.delete();
        prog.push_back(enc_i(OP_LUI, 5'd0, 5'd1, rand_bits(16)));
        prog.push_back(enc_i(OP_ORI, 5'd1, 5'd1, rand_bits(16)));
        prog.push_back(enc_i(OP_LUI, 5'd0, 5'd2, rand_bits(16)));
        prog.push_back(enc_i(OP_ORI, 5'd2, 5'd2, rand_bits(16)));
        prog.push_back(enc_i(OP_ANDI, 5'd1, 5'd3, rand_bits(16)));
        prog.push_back(enc_i(OP_XORI, 5'd2, 5'd4, rand_bits(16)));
        prog.push_back(enc_i(OP_ANDI, 5'd2, 5'd5, 32'h0000_ffff));
        prog.push_back(enc_i(OP_XORI, 5'd1, 5'd6, rand_bits(16)));
        run_program("immediate");
    endtask

    task automatic test_forwarding();
        prog.delete();
        prog.push_back(enc_i(OP_LUI, 5'd0, 5'd1, rand_bits(16)));
        prog.push_back(enc_i(OP_ORI, 5'd1, 5'd1, rand_bits(16)));  // distance 1
        prog.push_back(enc_r(FN_ADDU, 5'd2, 5'd1, 5'd1));
        prog.push_back(enc_r(FN_SUBU, 5'd3, 5'd2, 5'd1));         // distances 1 and 2
        prog.push_back(enc_i(OP_XORI, 5'd2, 5'd4, rand_bits(16)));
        prog.push_back(enc_r(FN_OR, 5'd5, 5'd3, 5'd2));           // distances 2 and 3
        prog.push_back('0);
        prog.push_back(enc_r(FN_AND, 5'd6, 5'd4, 5'd5));
        prog.push_back('0);
        prog.push_back('0);
        prog.push_back('0);
        prog.push_back(enc_r(FN_ADDU, 5'd7, 5'd6, 5'd1));         // from the register file
        run_program("forwarding");
    endtask

    task automatic test_register_ops();
        prog.delete();
        load_const(5'd8, rand_bits(32));
        load_const(5'd9, rand_bits(32));
        load_const(5'd10, rand_bits(32));
        load_const(5'd11, rand_bits(32));
        prog.push_back(enc_r(FN_ADDU, 5'd12, 5'd8, 5'd9));
        prog.push_back(enc_r(FN_SUBU, 5'd13, 5'd8, 5'd9));
        prog.push_back(enc_r(FN_SUBU, 5'd14, 5'd9, 5'd8));
        prog.push_back(enc_r(FN_AND, 5'd15, 5'd10, 5'd11));
        prog.push_back(enc_r(FN_OR, 5'd16, 5'd10, 5'd11));
        prog.push_back(enc_r(FN_XOR, 5'd17, 5'd10, 5'd11));
        prog.push_back(enc_r(FN_SUBU, 5'd18, 5'd0, 5'd10));  // wraps below zero
        run_program("register ops");
    endtask

    task automatic test_hilo();
        prog.delete();
        load_const(5'd8, rand_bits(32));
        load_const(5'd9, rand_bits(32));
        prog.push_back(enc_r(FN_MULTU, 5'd0, 5'd8, 5'd9));
        prog.push_back(enc_r(FN_MFHI, 5'd10, 5'd0, 5'd0));
        prog.push_back(enc_r(FN_MFLO, 5'd11, 5'd0, 5'd0));
        load_const(5'd12, rand_bits(32));
        load_const(5'd13, rand_bits(32));
        prog.push_back(enc_r(FN_MTHI, 5'd0, 5'd12, 5'd0));
        prog.push_back(enc_r(FN_MTLO, 5'd0, 5'd13, 5'd0));
        prog.push_back(enc_r(FN_MFHI, 5'd14, 5'd0, 5'd0));
        prog.push_back(enc_r(FN_MFLO, 5'd15, 5'd0, 5'd0));
        run_program("hilo");
    endtask

    task automatic test_zero_and_timing();
        prog.delete();
        prog.push_back(enc_i(OP_LUI, 5'd0, 5'd4, rand_bits(16)));
        prog.push_back(enc_i(OP_ORI, 5'd4, 5'd0, rand_bits(16)));  // r0 target
        prog.push_back(enc_r(FN_ADDU, 5'd0, 5'd4, 5'd4));
        prog.push_back(enc_r(FN_ADDU, 5'd6, 5'd0, 5'd4));
        prog.push_back(enc_r(FN_OR, 5'd7, 5'd0, 5'd0));
        prog.push_back(enc_r(FN_XOR, 5'd8, 5'd4, 5'd0));
        run_program("zero and timing");
    endtask

    initial begin
        rst_i = 1'b1;
        for (int k = 0; k < ROM_WORDS; k++) rom[k] = '0;
        test_immediate();
        test_forwarding();
        test_register_ops();
        test_hilo();
        test_zero_and_timing();
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
